//--- csr_subsys.f
+incdir+hw
hw/csr_pkg.sv
hw/csr_bus_if.sv
hw/csr_arbiter.sv
hw/csr_regfile.sv
hw/csr_subsys.sv
dv/csr_subsys_chk.sv
dv/csr_subsys_tb.sv

//--- dv/csr_subsys_chk.sv
`timescale 1ns/10ps

`include "csr_defs.svh"

module csr_subsys_chk (
    input logic                 i_clk,
    input logic                 i_nrst,
    input logic                 o_m0_req_ready,
    input logic                 o_m0_resp_valid,
    input logic                 i_m0_resp_ready,
    input logic [`CSR_XLEN-1:0] o_m0_resp_data,
    input logic                 o_m1_req_ready,
    input logic                 o_m1_resp_valid,
    input logic                 i_m1_resp_ready,
    input logic [`CSR_XLEN-1:0] o_m1_resp_data
);

    // A stalled response keeps its valid and data
    m0_resp_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_m0_resp_valid && !i_m0_resp_ready |=> o_m0_resp_valid && $stable(o_m0_resp_data))
        else $error("master 0 response changed before it was taken");

    m1_resp_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_m1_resp_valid && !i_m1_resp_ready |=> o_m1_resp_valid && $stable(o_m1_resp_data))
        else $error("master 1 response changed before it was taken");

    // Only one master sees the slave at a time
    resp_onehot: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(o_m0_resp_valid && o_m1_resp_valid))
        else $error("both masters see a response");

    ready_onehot: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(o_m0_req_ready && o_m1_req_ready))
        else $error("both masters see request ready");

endmodule

//--- dv/csr_subsys_tb.sv
`timescale 1ns/10ps

`include "csr_defs.svh"

module csr_subsys_tb import csr_pkg::*; ();

    typedef struct {
        int                   m;
        csr_op_e              op;
        logic [`CSR_AW-1:0]   addr;
        logic [`CSR_XLEN-1:0] data;
        bit                   pair;
        logic [`CSR_XLEN-1:0] exp_data;
        bit                   exp_exc;
        // Cycle reads are checked for growth, not for a fixed value
        bit                   is_cycle;
    } entry_t;

    logic                 i_clk;
    logic                 i_nrst;
    logic                 m_req_valid [2];
    csr_op_e              m_req_op [2];
    logic [`CSR_AW-1:0]   m_req_addr [2];
    logic [`CSR_XLEN-1:0] m_req_data [2];
    logic                 m_resp_ready [2];
    logic                 o_req_ready [2];
    logic                 o_resp_valid [2];
    logic [`CSR_XLEN-1:0] o_resp_data [2];
    logic                 o_resp_exc [2];

    entry_t               tbl [$];
    int                   done_seq [64];
    int                   seq_cnt;
    int                   errors;
    bit                   busy [2];
    logic [`CSR_XLEN-1:0] last_cycle;
    logic [31:0]          rng_state;

    csr_subsys uut (
        .i_clk           (i_clk),
        .i_nrst          (i_nrst),
        .i_m0_req_valid  (m_req_valid[0]),
        .o_m0_req_ready  (o_req_ready[0]),
        .i_m0_req_op     (m_req_op[0]),
        .i_m0_req_addr   (m_req_addr[0]),
        .i_m0_req_data   (m_req_data[0]),
        .o_m0_resp_valid (o_resp_valid[0]),
        .i_m0_resp_ready (m_resp_ready[0]),
        .o_m0_resp_data  (o_resp_data[0]),
        .o_m0_resp_exc   (o_resp_exc[0]),
        .i_m1_req_valid  (m_req_valid[1]),
        .o_m1_req_ready  (o_req_ready[1]),
        .i_m1_req_op     (m_req_op[1]),
        .i_m1_req_addr   (m_req_addr[1]),
        .i_m1_req_data   (m_req_data[1]),
        .o_m1_resp_valid (o_resp_valid[1]),
        .i_m1_resp_ready (m_resp_ready[1]),
        .o_m1_resp_data  (o_resp_data[1]),
        .o_m1_resp_exc   (o_resp_exc[1])
    );

    bind csr_subsys csr_subsys_chk u_chk (
        .i_clk           (i_clk),
        .i_nrst          (i_nrst),
        .o_m0_req_ready  (o_m0_req_ready),
        .o_m0_resp_valid (o_m0_resp_valid),
        .i_m0_resp_ready (i_m0_resp_ready),
        .o_m0_resp_data  (o_m0_resp_data),
        .o_m1_req_ready  (o_m1_req_ready),
        .o_m1_resp_valid (o_m1_resp_valid),
        .i_m1_resp_ready (i_m1_resp_ready),
        .o_m1_resp_data  (o_m1_resp_data)
    );

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_val(input string name, input logic [63:0] act,
                             input logic [63:0] exp);
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t: %s actual %h expected %h", $time, name, act, exp);
        end
    endtask

    task automatic flag_failure(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic add_entry(input int m, input csr_op_e op, input logic [11:0] addr,
                             input logic [31:0] data, input bit pair,
                             input logic [31:0] exp_data, input bit exp_exc,
                             input bit is_cycle);
        entry_t e;
        e.m        = m;
        e.op       = op;
        e.addr     = addr;
        e.data     = `CSR_XLEN'(data);
        e.pair     = pair;
        e.exp_data = `CSR_XLEN'(exp_data);
        e.exp_exc  = exp_exc;
        e.is_cycle = is_cycle;
        tbl.push_back(e);
    endtask

    // Expected values follow the CSR rules in table order
    task automatic fill_table();
        add_entry(0, CSR_OP_READ,  `CSR_A_MSCRATCH, 32'h0,        0, 32'h0,        0, 0);
        add_entry(0, CSR_OP_WRITE, `CSR_A_MSCRATCH, 32'h12345678, 0, 32'h0,        0, 0);
        add_entry(1, CSR_OP_SET,   `CSR_A_MSCRATCH, 32'h000000f0, 0, 32'h12345678, 0, 0);
        add_entry(0, CSR_OP_CLEAR, `CSR_A_MSCRATCH, 32'h00000078, 0, 32'h123456f8, 0, 0);
        add_entry(1, CSR_OP_READ,  `CSR_A_MSCRATCH, 32'h0,        0, 32'h12345680, 0, 0);
        add_entry(0, CSR_OP_WRITE, `CSR_A_MTVEC,    32'hffffffff, 0, 32'h0,        0, 0);
        add_entry(0, CSR_OP_READ,  `CSR_A_MTVEC,    32'h0,        0, 32'hfffffffc, 0, 0);
        add_entry(1, CSR_OP_WRITE, `CSR_A_MSTATUS,  32'hffffffff, 0, 32'h0,        0, 0);
        add_entry(1, CSR_OP_READ,  `CSR_A_MSTATUS,  32'h0,        0, 32'h88,       0, 0);
        // The write to cycle sits between two cycle reads
        add_entry(0, CSR_OP_READ,  `CSR_A_CYCLE,    32'h0,        0, 32'h0,        0, 1);
        add_entry(0, CSR_OP_WRITE, `CSR_A_CYCLE,    32'h5,        0, 32'h0,        1, 0);
        add_entry(1, CSR_OP_READ,  `CSR_A_CYCLE,    32'h0,        0, 32'h0,        0, 1);
        add_entry(0, CSR_OP_READ,  12'h123,         32'h0,        0, 32'h0,        1, 0);
        add_entry(1, CSR_OP_SET,   12'h7c0,         32'h1,        0, 32'h0,        1, 0);
        add_entry(0, CSR_OP_READ,  `CSR_A_MSCRATCH, 32'h0,        0, 32'h12345680, 0, 0);
        // Simultaneous pairs where master 0 is served first
        add_entry(0, CSR_OP_WRITE, `CSR_A_MSCRATCH, 32'ha5a5a5a5, 1, 32'h12345680, 0, 0);
        add_entry(1, CSR_OP_READ,  `CSR_A_MSCRATCH, 32'h0,        0, 32'ha5a5a5a5, 0, 0);
        add_entry(0, CSR_OP_READ,  `CSR_A_MSTATUS,  32'h0,        1, 32'h88,       0, 0);
        add_entry(1, CSR_OP_CLEAR, `CSR_A_MSTATUS,  32'h08,       0, 32'h88,       0, 0);
        add_entry(0, CSR_OP_READ,  `CSR_A_MSTATUS,  32'h0,        0, 32'h80,       0, 0);
        add_entry(1, CSR_OP_SET,   `CSR_A_CYCLE,    32'h1,        0, 32'h0,        1, 0);
        add_entry(0, CSR_OP_SET,   `CSR_A_MTVEC,    32'h3,        1, 32'hfffffffc, 0, 0);
        add_entry(1, CSR_OP_READ,  `CSR_A_MTVEC,    32'h0,        0, 32'hfffffffc, 0, 0);
    endtask

    // One transaction on one master with random response back-pressure
    task automatic run_entry(input int idx);
        entry_t               e;
        int                   m;
        bit                   got;
        logic [`CSR_XLEN-1:0] data;
        logic                 exc;
        logic [31:0]          r;
        e = tbl[idx];
        m = e.m;
        @(posedge i_clk);
        m_req_valid[m] <= 1'b1;
        m_req_op[m]    <= e.op;
        m_req_addr[m]  <= e.addr;
        m_req_data[m]  <= e.data;
        got = 1'b0;
        while (!got) begin
            @(negedge i_clk);
            got = o_req_ready[m];
        end
        @(posedge i_clk);
        // Request taken on this edge, a response may follow from now on
        busy[m] = 1'b1;
        m_req_valid[m] <= 1'b0;
        r = xorshift32();
        m_resp_ready[m] <= r[0] | r[1];
        got = 1'b0;
        while (!got) begin
            @(negedge i_clk);
            got  = o_resp_valid[m] && m_resp_ready[m];
            data = o_resp_data[m];
            exc  = o_resp_exc[m];
            @(posedge i_clk);
            if (got) begin
                m_resp_ready[m] <= 1'b0;
            end else begin
                r = xorshift32();
                m_resp_ready[m] <= r[0] | r[1];
            end
        end
        busy[m] = 1'b0;
        done_seq[idx] = seq_cnt;
        seq_cnt++;
        check_val($sformatf("entry %0d resp_exc", idx), 64'(exc), 64'(e.exp_exc));
        if (e.is_cycle) begin
            if (!(data > last_cycle)) begin
                flag_failure($sformatf("entry %0d cycle value %h did not grow past %h",
                                       idx, data, last_cycle));
            end
            last_cycle = data;
        end else begin
            check_val($sformatf("entry %0d resp_data", idx), 64'(data), 64'(e.exp_data));
        end
    endtask

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // Responses only on a master waiting for one and no grant to the other master
    always @(negedge i_clk) begin
        if (i_nrst) begin
            if (o_resp_valid[0] && !busy[0]) begin
                flag_failure("master 0 got a response it was not waiting for");
            end
            if (o_resp_valid[1] && !busy[1]) begin
                flag_failure("master 1 got a response it was not waiting for");
            end
            if (o_resp_valid[0] && o_req_ready[1]) begin
                flag_failure("master 1 saw request ready during a master 0 response");
            end
            if (o_resp_valid[1] && o_req_ready[0]) begin
                flag_failure("master 0 saw request ready during a master 1 response");
            end
        end
    end

    initial begin
        #1;
        repeat (tbl.size() * 64) @(posedge i_clk);
        $display("Error: the run timed out waiting for a DUT handshake");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int i;
        i_nrst     = 1'b0;
        errors     = 0;
        seq_cnt    = 0;
        last_cycle = '0;
        rng_state  = 32'hfce5f347;
        for (int k = 0; k < 2; k++) begin
            m_req_valid[k]  = 1'b0;
            m_req_op[k]     = CSR_OP_READ;
            m_req_addr[k]   = '0;
            m_req_data[k]   = '0;
            m_resp_ready[k] = 1'b0;
            busy[k]         = 1'b0;
        end
        fill_table();
        repeat (4) @(posedge i_clk);
        i_nrst <= 1'b1;
        i = 0;
        while (i < tbl.size()) begin
            if (tbl[i].pair) begin
                fork
                    run_entry(i);
                    run_entry(i + 1);
                join
                if (done_seq[i] >= done_seq[i + 1]) begin
                    flag_failure($sformatf("entry %0d was served after entry %0d",
                                           i, i + 1));
                end
                i += 2;
            end else begin
                run_entry(i);
                i++;
            end
        end
        repeat (2) @(posedge i_clk);
        $display("Run complete: %0d entries, %0d errors", tbl.size(), errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- hw/csr_arbiter.sv
`timescale 1ns/10ps

module csr_arbiter (
    input logic     i_clk,
    input logic     i_nrst,
    csr_bus_if.slave  m0,
    csr_bus_if.slave  m1,
    csr_bus_if.master s0
);

    logic lock_q;
    // Granted master, 0 or 1
    logic sel_q;
    logic route_m1;

    // Idle bus goes to master 0 if it asks, otherwise to master 1
    always_comb begin
        if (lock_q) begin
            route_m1 = sel_q;
        end else begin
            route_m1 = ~m0.req_valid;
        end
    end

    // Grant lock, held until the granted master takes its response
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            lock_q <= 1'b0;
            sel_q  <= 1'b0;
        end else if (!lock_q) begin
            if (m0.req_valid || m1.req_valid) begin
                lock_q <= 1'b1;
                sel_q  <= ~m0.req_valid;
            end
        end else if (s0.resp_valid && s0.resp_ready) begin
            lock_q <= 1'b0;
        end
    end

    // Routing between the selected master and the slave
    always_comb begin
        if (!route_m1) begin
            s0.req_valid  = m0.req_valid;
            s0.req_op     = m0.req_op;
            s0.req_addr   = m0.req_addr;
            s0.req_data   = m0.req_data;
            s0.resp_ready = m0.resp_ready;
            m0.req_ready  = s0.req_ready;
            m0.resp_valid = s0.resp_valid;
            m0.resp_data  = s0.resp_data;
            m0.resp_exc   = s0.resp_exc;
            // Master 1 is parked
            m1.req_ready  = 1'b0;
            m1.resp_valid = 1'b0;
            m1.resp_data  = '0;
            m1.resp_exc   = 1'b0;
        end else begin
            s0.req_valid  = m1.req_valid;
            s0.req_op     = m1.req_op;
            s0.req_addr   = m1.req_addr;
            s0.req_data   = m1.req_data;
            s0.resp_ready = m1.resp_ready;
            m1.req_ready  = s0.req_ready;
            m1.resp_valid = s0.resp_valid;
            m1.resp_data  = s0.resp_data;
            m1.resp_exc   = s0.resp_exc;
            // Master 0 is parked
            m0.req_ready  = 1'b0;
            m0.resp_valid = 1'b0;
            m0.resp_data  = '0;
            m0.resp_exc   = 1'b0;
        end
    end

endmodule

//--- hw/csr_bus_if.sv
`timescale 1ns/10ps

`include "csr_defs.svh"

interface csr_bus_if import csr_pkg::*;;

    // Request channel
    logic                 req_valid;
    logic                 req_ready;
    csr_op_e              req_op;
    logic [`CSR_AW-1:0]   req_addr;
    logic [`CSR_XLEN-1:0] req_data;

    // Response channel
    logic                 resp_valid;
    logic                 resp_ready;
    logic [`CSR_XLEN-1:0] resp_data;
    logic                 resp_exc;

    modport master (
        output req_valid, req_op, req_addr, req_data,
        input  req_ready,
        input  resp_valid, resp_data, resp_exc,
        output resp_ready
    );

    modport slave (
        input  req_valid, req_op, req_addr, req_data,
        output req_ready,
        output resp_valid, resp_data, resp_exc,
        input  resp_ready
    );

endinterface

//--- hw/csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Data and address widths
`define CSR_XLEN 32
`define CSR_AW 12

// Implemented machine CSR addresses
`define CSR_A_MSTATUS 12'h300
`define CSR_A_MTVEC 12'h305
`define CSR_A_MSCRATCH 12'h340
`define CSR_A_CYCLE 12'hC00

// Writable bits of mstatus (MIE and MPIE)
`define CSR_MSTATUS_WMASK 8'h88

`endif

//--- hw/csr_pkg.sv
`include "csr_defs.svh"

package csr_pkg;

    // CSR access operation, RISC-V csrrw/csrrs/csrrc style
    typedef enum logic [1:0] {
        CSR_OP_READ  = 2'd0,
        CSR_OP_WRITE = 2'd1,
        CSR_OP_SET   = 2'd2,
        CSR_OP_CLEAR = 2'd3
    } csr_op_e;

    // Standard field split of a CSR address
    typedef struct packed {
        // 2'b11 marks the read-only space
        logic [1:0] access;
        // Lowest privilege level allowed to access
        logic [1:0] priv;
        logic [7:0] index;
    } csr_addr_fields_t;

    // Same address word seen as a raw number or as its fields
    typedef union packed {
        logic [`CSR_AW-1:0] raw;
        csr_addr_fields_t   f;
    } csr_addr_u;

endpackage

//--- hw/csr_regfile.sv
`timescale 1ns/10ps

`include "csr_defs.svh"

module csr_regfile import csr_pkg::*; (
    input logic      i_clk,
    input logic      i_nrst,
    csr_bus_if.slave bus
);

    localparam int xlen = `CSR_XLEN;
    localparam logic [xlen-1:0] mstatus_wmask = xlen'(`CSR_MSTATUS_WMASK);
    // mtvec is word aligned, mode bits fixed to direct
    localparam logic [xlen-1:0] mtvec_wmask = ~xlen'(3);

    logic [xlen-1:0] mscratch_q;
    logic [xlen-1:0] mtvec_q;
    logic [xlen-1:0] mstatus_q;
    logic [xlen-1:0] cycle_q;

    logic            resp_valid_q;
    logic [xlen-1:0] resp_data_q;
    logic            resp_exc_q;

    csr_addr_u       addr;
    logic            hit;
    logic            ro_viol;
    logic            exc;
    logic            accept;
    logic            wr_en;
    logic [xlen-1:0] old_val;
    logic [xlen-1:0] new_val;

    assign addr   = bus.req_addr;
    assign accept = bus.req_valid && bus.req_ready;

    // Address match and old value
    always_comb begin
        hit     = 1'b1;
        old_val = '0;
        case (addr.raw)
            `CSR_A_MSTATUS:  old_val = mstatus_q;
            `CSR_A_MTVEC:    old_val = mtvec_q;
            `CSR_A_MSCRATCH: old_val = mscratch_q;
            `CSR_A_CYCLE:    old_val = cycle_q;
            default:         hit = 1'b0;
        endcase
    end

    // Any modifying op in the read-only space traps
    assign ro_viol = (bus.req_op != CSR_OP_READ) && (addr.f.access == 2'b11);
    assign exc     = !hit || ro_viol;
    assign wr_en   = accept && !exc && (bus.req_op != CSR_OP_READ);

    always_comb begin
        case (bus.req_op)
            CSR_OP_WRITE: new_val = bus.req_data;
            CSR_OP_SET:   new_val = old_val | bus.req_data;
            CSR_OP_CLEAR: new_val = old_val & ~bus.req_data;
            default:      new_val = old_val;
        endcase
    end

    // Storage, cycle runs free every clock
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            mscratch_q <= '0;
            mtvec_q    <= '0;
            mstatus_q  <= '0;
            cycle_q    <= '0;
        end else begin
            cycle_q <= cycle_q + 1'b1;
            if (wr_en) begin
                case (addr.raw)
                    `CSR_A_MSTATUS:  mstatus_q <= new_val & mstatus_wmask;
                    `CSR_A_MTVEC:    mtvec_q <= new_val & mtvec_wmask;
                    `CSR_A_MSCRATCH: mscratch_q <= new_val;
                    default:         ;
                endcase
            end
        end
    end

    // One outstanding response
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            resp_valid_q <= 1'b0;
        end else if (accept) begin
            resp_valid_q <= 1'b1;
        end else if (bus.resp_ready) begin
            resp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            resp_data_q <= exc ? '0 : old_val;
            resp_exc_q  <= exc;
        end
    end

    assign bus.req_ready  = !resp_valid_q;
    assign bus.resp_valid = resp_valid_q;
    assign bus.resp_data  = resp_data_q;
    assign bus.resp_exc   = resp_exc_q;

endmodule

//--- hw/csr_subsys.sv
`timescale 1ns/10ps

`include "csr_defs.svh"

module csr_subsys import csr_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_nrst,
    // Master 0, instruction pipeline
    input  logic                 i_m0_req_valid,
    output logic                 o_m0_req_ready,
    input  csr_op_e              i_m0_req_op,
    input  logic [`CSR_AW-1:0]   i_m0_req_addr,
    input  logic [`CSR_XLEN-1:0] i_m0_req_data,
    output logic                 o_m0_resp_valid,
    input  logic                 i_m0_resp_ready,
    output logic [`CSR_XLEN-1:0] o_m0_resp_data,
    output logic                 o_m0_resp_exc,
    // Master 1, debug module
    input  logic                 i_m1_req_valid,
    output logic                 o_m1_req_ready,
    input  csr_op_e              i_m1_req_op,
    input  logic [`CSR_AW-1:0]   i_m1_req_addr,
    input  logic [`CSR_XLEN-1:0] i_m1_req_data,
    output logic                 o_m1_resp_valid,
    input  logic                 i_m1_resp_ready,
    output logic [`CSR_XLEN-1:0] o_m1_resp_data,
    output logic                 o_m1_resp_exc
);

    csr_bus_if m0_bus ();
    csr_bus_if m1_bus ();
    csr_bus_if s0_bus ();

    assign m0_bus.req_valid  = i_m0_req_valid;
    assign m0_bus.req_op     = i_m0_req_op;
    assign m0_bus.req_addr   = i_m0_req_addr;
    assign m0_bus.req_data   = i_m0_req_data;
    assign m0_bus.resp_ready = i_m0_resp_ready;
    assign o_m0_req_ready    = m0_bus.req_ready;
    assign o_m0_resp_valid   = m0_bus.resp_valid;
    assign o_m0_resp_data    = m0_bus.resp_data;
    assign o_m0_resp_exc     = m0_bus.resp_exc;

    assign m1_bus.req_valid  = i_m1_req_valid;
    assign m1_bus.req_op     = i_m1_req_op;
    assign m1_bus.req_addr   = i_m1_req_addr;
    assign m1_bus.req_data   = i_m1_req_data;
    assign m1_bus.resp_ready = i_m1_resp_ready;
    assign o_m1_req_ready    = m1_bus.req_ready;
    assign o_m1_resp_valid   = m1_bus.resp_valid;
    assign o_m1_resp_data    = m1_bus.resp_data;
    assign o_m1_resp_exc     = m1_bus.resp_exc;

    csr_arbiter u_arbiter (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .m0     (m0_bus.slave),
        .m1     (m1_bus.slave),
        .s0     (s0_bus.master)
    );

    csr_regfile u_regfile (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .bus    (s0_bus.slave)
    );

endmodule

//--- run.sh
#!/bin/sh
# Build and run the CSR subsystem testbench; exit status follows the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f csr_subsys.f \
    --top-module csr_subsys_tb -o csr_subsys_sim &&
./obj_dir/csr_subsys_sim | tee /dev/stderr | grep -q "^TESTBENCH PASSED$" &&
exit 0 || exit 1
